//--- common/fhbuf_pkg.sv
package fhbuf_pkg;

   // sample counts and ram addresses
   localparam int SAMPLE_CNT_W = 15;

   localparam int PRECISION = 16;   // bits per iq component

   typedef struct packed {
      logic [PRECISION-1:0] imag_part;
      logic [PRECISION-1:0] real_part;
   } iq_sample_t;

   // one beat of a dfe stream, no back-pressure
   typedef struct packed {
      logic       valid;
      logic [1:0] user;   // antenna slot
      iq_sample_t data;
   } stream_beat_t;

   typedef struct packed {
      logic                    store_en;     // capture allowed
      logic                    play_en;      // playback allowed
      logic                    loop;         // repeat playback until play_en drops
      logic [1:0]              ant_sel;      // input antenna to capture from
      logic [SAMPLE_CNT_W-1:0] num_samples;
   } test_ctrl_t;

   // sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_WAIT_MRKR,
      SEQ_STORE,
      SEQ_PLAY
   } seq_state_t;

endpackage

//--- hdl/start_sync.sv
`timescale 1ns/1ps

module start_sync (
   input  logic clk_1x,
   input  logic resetn,
   input  logic start_req,
   output logic start_ack,
   output logic start_pulse
);

   logic [1:0] req_sync;   // two flop synchronizer

   // ack follows the synchronized request one cycle later,
   // pulse marks the cycle in which ack goes high
   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         req_sync    <= 2'b00;
         start_ack   <= 1'b0;
         start_pulse <= 1'b0;
      end else begin
         req_sync    <= {req_sync[0], start_req};
         start_ack   <= req_sync[1];
         start_pulse <= req_sync[1] & ~start_ack;   // rising edge only
      end
   end

   // host must keep start_req low until ack has dropped
   a_ack_no_early_fall : assert property (
      @(posedge clk_1x) disable iff (!resetn)
      $fell(start_ack) |-> !req_sync[1]
   ) else $error("start_ack fell while request still high");

endmodule

//--- hdl/sample_ram.sv
`timescale 1ns/1ps

module sample_ram import fhbuf_pkg::*; #(
   parameter int RAM_DEPTH = 4096
) (
   input  logic                    clk_1x,
   input  logic [SAMPLE_CNT_W-1:0] addr,
   input  logic                    we,
   input  iq_sample_t              wdata,
   output iq_sample_t              rdata
);

   localparam int IDX_W = $clog2(RAM_DEPTH);

   iq_sample_t       mem [RAM_DEPTH];
   logic [IDX_W-1:0] idx;

   assign idx = addr[IDX_W-1:0];   // upper address bits alias

   // read returns the old word on a same-address write
   always_ff @(posedge clk_1x) begin
      if (we) begin
         mem[idx] <= wdata;
      end
      rdata <= mem[idx];
   end

endmodule

//--- fhbuf_ctrl/fhbuf_addr_seq.sv
`timescale 1ns/1ps

module fhbuf_addr_seq import fhbuf_pkg::*; #(
   parameter int N_ANTS_SEL  = 2,
   parameter int N_ANT_SLOTS = 4
) (
   input  logic                    clk_1x,
   input  logic                    resetn,
   input  logic                    sample_en,
   input  logic                    start_pulse,
   input  logic                    frm_mrkr,
   input  test_ctrl_t              test_ctrl,
   input  stream_beat_t            dfe_in [N_ANTS_SEL],
   output logic [SAMPLE_CNT_W-1:0] ram_addr,
   output logic                    ram_we,
   output iq_sample_t              ram_wdata,
   input  iq_sample_t              ram_rdata,
   output iq_sample_t              play_sample,
   output logic                    play_valid
);

   localparam int SLOT_W = (N_ANT_SLOTS > 1) ? $clog2(N_ANT_SLOTS) : 1;
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(N_ANT_SLOTS - 1);

   seq_state_t              state;
   stream_beat_t            sel_beat;
   stream_beat_t            in_reg;      // selected input, one cycle late
   logic [SAMPLE_CNT_W-1:0] ptr;         // sample pointer
   logic [SAMPLE_CNT_W-1:0] last_addr;
   logic [SLOT_W-1:0]       slot;        // antenna slot within a sample
   logic                    start_pend;
   logic                    start_go;
   logic                    beat_ok;
   logic                    store_wr;
   logic                    play_last;

   // out of range ant_sel gives an idle beat
   always_comb begin
      sel_beat = '0;
      for (int i = 0; i < N_ANTS_SEL; i++) begin
         if (test_ctrl.ant_sel == 2'(i)) begin
            sel_beat = dfe_in[i];
         end
      end
   end

   always_ff @(posedge clk_1x) begin
      in_reg <= sel_beat;
   end

   assign start_go  = start_pend | start_pulse;   // pulse may coincide with the enable
   assign beat_ok   = in_reg.valid && (in_reg.user == 2'd0);
   assign last_addr = test_ctrl.num_samples - SAMPLE_CNT_W'(1);

   assign store_wr = sample_en && (state == SEQ_STORE) && test_ctrl.store_en
                     && (ptr != test_ctrl.num_samples) && beat_ok;
   assign play_last = sample_en && (state == SEQ_PLAY) && test_ctrl.play_en
                      && (slot == LAST_SLOT);

   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         state      <= SEQ_IDLE;
         ptr        <= '0;
         slot       <= '0;
         start_pend <= 1'b0;
         ram_we     <= 1'b0;
         ram_addr   <= '0;
         play_valid <= 1'b0;
      end else begin
         ram_we <= 1'b0;   // single clock write strobe
         if (start_pulse && state == SEQ_IDLE) begin
            start_pend <= 1'b1;
         end
         if (sample_en) begin
            start_pend <= 1'b0;
            play_valid <= 1'b0;   // held for one enable period
            case (state)
               SEQ_IDLE: begin
                  ptr  <= '0;
                  slot <= '0;
                  if (start_go) begin
                     if (test_ctrl.play_en && test_ctrl.num_samples != '0) begin
                        state <= SEQ_PLAY;
                     end else if (test_ctrl.store_en) begin
                        state <= SEQ_WAIT_MRKR;
                     end
                  end
               end
               SEQ_WAIT_MRKR: begin
                  if (!test_ctrl.store_en) begin
                     state <= SEQ_IDLE;
                  end else if (frm_mrkr) begin
                     state <= SEQ_STORE;
                  end
               end
               SEQ_STORE: begin
                  // zero count lands here and leaves without a write
                  if (!test_ctrl.store_en || ptr == test_ctrl.num_samples) begin
                     state <= SEQ_IDLE;
                     ptr   <= '0;
                  end else if (beat_ok) begin
                     ram_we   <= 1'b1;
                     ram_addr <= ptr;
                     ptr      <= ptr + 1'b1;
                  end
               end
               SEQ_PLAY: begin
                  if (!test_ctrl.play_en) begin
                     state <= SEQ_IDLE;
                     ptr   <= '0;
                     slot  <= '0;
                  end else begin
                     if (slot == '0) begin
                        ram_addr <= ptr;   // read settles long before the last slot
                     end
                     if (slot == LAST_SLOT) begin
                        slot       <= '0;
                        play_valid <= 1'b1;
                        if (ptr == last_addr) begin
                           ptr <= '0;
                           if (!test_ctrl.loop) begin
                              state <= SEQ_IDLE;
                           end
                        end else begin
                           ptr <= ptr + 1'b1;
                        end
                     end else begin
                        slot <= slot + 1'b1;
                     end
                  end
               end
               default: state <= SEQ_IDLE;
            endcase
         end
      end
   end

   // payload registers
   always_ff @(posedge clk_1x) begin
      if (store_wr) begin
         ram_wdata <= in_reg.data;
      end
      if (play_last) begin
         play_sample <= ram_rdata;
      end
   end

   // writes stay inside the requested sample count
   a_we_only_store : assert property (
      @(posedge clk_1x) disable iff (!resetn)
      ram_we |-> ((state == SEQ_STORE) && (ram_addr < test_ctrl.num_samples))
   ) else $error("ram write outside of capture range");

   // num_samples is expected to stay stable during a run
   a_ptr_in_range : assert property (
      @(posedge clk_1x) disable iff (!resetn)
      (state == SEQ_PLAY) |-> (ptr < test_ctrl.num_samples)
   ) else $error("playback pointer beyond num_samples");

endmodule

//--- fhbuf_ctrl/fhbuf_out_drive.sv
`timescale 1ns/1ps

module fhbuf_out_drive import fhbuf_pkg::*; #(
   parameter int N_ANT_SLOTS = 4
) (
   input  logic         clk_1x,
   input  logic         resetn,
   input  logic         sample_en,
   input  iq_sample_t   play_sample,
   input  logic         play_valid,
   output stream_beat_t dfe_out
);

   localparam logic [1:0] LAST_USER = 2'(N_ANT_SLOTS - 1);

   typedef enum logic {
      DRV_IDLE,
      DRV_ACTIVE
   } drv_state_t;

   drv_state_t drv_state;
   logic       out_valid;
   logic [1:0] out_user;
   iq_sample_t out_data;

   // one beat per enable, stop once a full slot round passes with no new sample
   always_ff @(posedge clk_1x) begin
      if (!resetn) begin
         drv_state <= DRV_IDLE;
         out_valid <= 1'b0;
         out_user  <= 2'd0;
      end else if (sample_en) begin
         case (drv_state)
            DRV_IDLE: begin
               if (play_valid) begin
                  drv_state <= DRV_ACTIVE;
                  out_valid <= 1'b1;
                  out_user  <= 2'd0;
               end
            end
            DRV_ACTIVE: begin
               if (!play_valid && out_user == LAST_USER) begin
                  drv_state <= DRV_IDLE;
                  out_valid <= 1'b0;
                  out_user  <= 2'd0;
               end else if (out_user == LAST_USER) begin
                  out_user <= 2'd0;   // next sample
               end else begin
                  out_user <= out_user + 2'd1;
               end
            end
            default: drv_state <= DRV_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_1x) begin
      if (sample_en) begin
         out_data <= play_sample;   // always the latest sample
      end
   end

   assign dfe_out = '{valid: out_valid, user: out_user, data: out_data};

   // a new sample lines up with the end of a slot round
   a_user_in_range : assert property (
      @(posedge clk_1x) disable iff (!resetn)
      (sample_en && play_valid && drv_state == DRV_ACTIVE) |-> (out_user == LAST_USER)
   ) else $error("play sample arrived in the middle of a slot round");

endmodule

//--- hdl/fhbuf_input.sv
`timescale 1ns/1ps

module fhbuf_input import fhbuf_pkg::*; #(
   parameter int N_ANTS_SEL  = 2,
   parameter int N_ANT_SLOTS = 4,
   parameter int RAM_DEPTH   = 4096
) (
   input  logic         clk_1x,
   input  logic         resetn,
   input  logic         sample_en,
   input  logic         start_req,
   output logic         start_ack,
   input  logic         frm_mrkr,
   input  test_ctrl_t   test_ctrl,
   input  stream_beat_t dfe_in [N_ANTS_SEL],
   output stream_beat_t dfe_out
);

   logic                    start_pulse;
   logic [SAMPLE_CNT_W-1:0] ram_addr;
   logic                    ram_we;
   iq_sample_t              ram_wdata;
   iq_sample_t              ram_rdata;
   iq_sample_t              play_sample;
   logic                    play_valid;

   start_sync i_start_sync (
      .clk_1x      (clk_1x),
      .resetn      (resetn),
      .start_req   (start_req),
      .start_ack   (start_ack),
      .start_pulse (start_pulse)
   );

   fhbuf_addr_seq #(
      .N_ANTS_SEL  (N_ANTS_SEL),
      .N_ANT_SLOTS (N_ANT_SLOTS)
   ) i_fhbuf_addr_seq (
      .clk_1x      (clk_1x),
      .resetn      (resetn),
      .sample_en   (sample_en),
      .start_pulse (start_pulse),
      .frm_mrkr    (frm_mrkr),
      .test_ctrl   (test_ctrl),
      .dfe_in      (dfe_in),
      .ram_addr    (ram_addr),
      .ram_we      (ram_we),
      .ram_wdata   (ram_wdata),
      .ram_rdata   (ram_rdata),
      .play_sample (play_sample),
      .play_valid  (play_valid)
   );

   sample_ram #(
      .RAM_DEPTH (RAM_DEPTH)
   ) i_sample_ram (
      .clk_1x (clk_1x),
      .addr   (ram_addr),
      .we     (ram_we),
      .wdata  (ram_wdata),
      .rdata  (ram_rdata)
   );

   fhbuf_out_drive #(
      .N_ANT_SLOTS (N_ANT_SLOTS)
   ) i_fhbuf_out_drive (
      .clk_1x      (clk_1x),
      .resetn      (resetn),
      .sample_en   (sample_en),
      .play_sample (play_sample),
      .play_valid  (play_valid),
      .dfe_out     (dfe_out)
   );

endmodule

//--- verif/tb_fhbuf_input.sv
`timescale 1ns/1ps

module tb_fhbuf_input import fhbuf_pkg::*;;

   localparam int N_ANTS_SEL  = 2;
   localparam int N_ANT_SLOTS = 4;
   localparam int RAM_DEPTH   = 4096;

   logic         clk_1x;
   logic         resetn;
   logic         sample_en;
   logic         start_req;
   logic         start_ack;
   logic         frm_mrkr;
   test_ctrl_t   test_ctrl;
   stream_beat_t dfe_in [N_ANTS_SEL];
   stream_beat_t dfe_out;

   // model state
   iq_sample_t   model_mem [64];
   stream_beat_t got_q [$];
   iq_sample_t   other_q [$];     // antenna 0 user 0 beats seen while capturing antenna 1
   int           cap_phase;       // 0 off, 1 waiting for marker, 2 storing
   int           cap_cnt;
   int           cap_n;
   int           cyc;
   int           errors;
   int           tests_failed;
   bit           collect_on;
   bit           mrkr_req;
   bit           force_invalid;

   fhbuf_input #(
      .N_ANTS_SEL  (N_ANTS_SEL),
      .N_ANT_SLOTS (N_ANT_SLOTS),
      .RAM_DEPTH   (RAM_DEPTH)
   ) i_fhbuf_input (
      .clk_1x    (clk_1x),
      .resetn    (resetn),
      .sample_en (sample_en),
      .start_req (start_req),
      .start_ack (start_ack),
      .frm_mrkr  (frm_mrkr),
      .test_ctrl (test_ctrl),
      .dfe_in    (dfe_in),
      .dfe_out   (dfe_out)
   );

   always #50 clk_1x = ~clk_1x;

   function automatic seq_state_t dut_state();
      return i_fhbuf_input.i_fhbuf_addr_seq.state;
   endfunction

   task automatic give_up(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $finish;
   endtask

   // capture rule applied to the beat the DUT saw on this enable
   task automatic model_enable();
      stream_beat_t b;
      b = dfe_in[test_ctrl.ant_sel[0]];
      if (cap_phase == 2) begin
         if (!test_ctrl.store_en || cap_cnt == cap_n) begin
            cap_phase = 0;
         end else if (b.valid && b.user == 2'd0) begin
            model_mem[cap_cnt] = b.data;
            cap_cnt++;
         end
         if (test_ctrl.ant_sel[0] && dfe_in[0].valid && dfe_in[0].user == 2'd0) begin
            other_q.push_back(dfe_in[0].data);
         end
      end else if (cap_phase == 1) begin
         if (!test_ctrl.store_en) begin
            cap_phase = 0;
         end else if (frm_mrkr) begin
            cap_phase = 2;
         end
      end
   endtask

   // one clock, values read first belong to the cycle just ended
   task automatic step_cycle();
      stream_beat_t b;
      logic [31:0]  r;
      @(posedge clk_1x);
      if (sample_en) begin
         model_enable();
         if (collect_on && dfe_out.valid) begin
            got_q.push_back(dfe_out);
         end
      end
      cyc++;
      case (cyc % 4)
         2: begin   // new beats one cycle ahead of the enable
            for (int i = 0; i < N_ANTS_SEL; i++) begin
               r = $urandom;
               b.valid = force_invalid ? 1'b0 : r[0];
               b.user  = r[2:1];
               b.data  = $urandom;
               dfe_in[i] <= b;
            end
            frm_mrkr  <= mrkr_req;
            mrkr_req   = 1'b0;
            sample_en <= 1'b0;
         end
         3: sample_en <= 1'b1;
         default: sample_en <= 1'b0;
      endcase
   endtask

   task automatic set_ctrl(input bit se, input bit pe, input bit lp, input int ant,
                           input int n);
      test_ctrl <= '{store_en: se, play_en: pe, loop: lp, ant_sel: 2'(ant),
                     num_samples: SAMPLE_CNT_W'(n)};
   endtask

   task automatic do_start();
      int t;
      t = 0;
      start_req <= 1'b1;
      while (start_ack !== 1'b1) begin
         step_cycle();
         t++;
         if (t > 50) give_up("start_ack did not rise after start_req was raised");
      end
      start_req <= 1'b0;
      t = 0;
      while (start_ack !== 1'b0) begin
         step_cycle();
         t++;
         if (t > 50) give_up("start_ack did not fall after start_req was dropped");
      end
   endtask

   task automatic wait_state(input seq_state_t s);
      int t;
      t = 0;
      while (dut_state() != s) begin
         step_cycle();
         t++;
         if (t > 20000) give_up($sformatf("sequencer never reached %s", s.name()));
      end
   endtask

   task automatic run_capture(input int ant, input int n, input int abort_after,
                              input bit restart);
      int t;
      set_ctrl(1'b1, 1'b0, 1'b0, ant, n);
      cap_n   = n;
      cap_cnt = 0;
      other_q.delete();
      step_cycle();
      do_start();
      wait_state(SEQ_WAIT_MRKR);
      cap_phase = 1;
      mrkr_req  = 1'b1;
      t = 0;
      while (cap_phase != 2) begin
         step_cycle();
         t++;
         if (t > 100) give_up("frame marker was never taken by the model");
      end
      if (restart) begin
         do_start();   // must be ignored, capture is running
      end
      if (abort_after > 0) begin
         t = 0;
         while (cap_cnt < abort_after) begin
            step_cycle();
            t++;
            if (t > 20000) give_up("capture wrote too few samples before abort");
         end
         force_invalid = 1'b1;
         repeat (10) step_cycle();   // invalid beats now on the inputs
         test_ctrl.store_en <= 1'b0;
         t = 0;
         while (dut_state() != SEQ_IDLE) begin
            step_cycle();
            t++;
            if (t > 8) give_up("capture kept running after store_en dropped");
         end
      end
      wait_state(SEQ_IDLE);
      step_cycle();
      force_invalid = 1'b0;
      if (abort_after == 0 && cap_cnt != n) begin
         $display("FAIL %0t: capture stored %0d of %0d samples", $time, cap_cnt, n);
         errors++;
      end
   endtask

   task automatic run_playback(input int n, input bit do_loop);
      int           t;
      stream_beat_t exp;
      seq_state_t   st;
      got_q.delete();
      set_ctrl(1'b0, 1'b1, do_loop, 0, n);
      collect_on = 1'b1;
      step_cycle();
      do_start();
      t = 0;
      while (!(got_q.size() > 0 && !dfe_out.valid)) begin
         step_cycle();
         t++;
         if (do_loop && got_q.size() >= 3 * n * N_ANT_SLOTS && test_ctrl.play_en) begin
            test_ctrl.play_en <= 1'b0;
         end
         if (t > 20000) give_up("dfe_out.valid did not fall at the end of playback");
      end
      collect_on = 1'b0;
      for (int i = 0; i < 32; i++) begin
         step_cycle();
         if (dfe_out.valid) begin
            $display("FAIL %0t: dfe_out.valid high after playback ended", $time);
            errors++;
         end
      end
      if (!do_loop && got_q.size() != n * N_ANT_SLOTS) begin
         $display("FAIL %0t: got %0d beats, expected %0d", $time, got_q.size(),
                  n * N_ANT_SLOTS);
         errors++;
      end
      if (do_loop && got_q.size() < 3 * n * N_ANT_SLOTS) begin
         $display("FAIL %0t: loop gave only %0d beats", $time, got_q.size());
         errors++;
      end
      foreach (got_q[k]) begin
         exp.valid = 1'b1;
         exp.user  = 2'(k % N_ANT_SLOTS);
         exp.data  = model_mem[(k / N_ANT_SLOTS) % n];
         if (got_q[k] !== exp) begin
            $display("FAIL %0t: beat %0d is %h, expected %h", $time, k, got_q[k], exp);
            errors++;
         end
      end
      st = dut_state();
      if (st != SEQ_IDLE) begin
         $display("FAIL %0t: sequencer in %s after playback", $time, st.name());
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_before);
         tests_failed++;
      end
   endtask

   initial begin
      int          e0;
      int          n3;
      int          n4;
      logic [31:0] r;
      r = $urandom(32'h6f0a);
      clk_1x        = 1'b0;
      resetn        = 1'b0;
      sample_en     = 1'b0;
      start_req     = 1'b0;
      frm_mrkr      = 1'b0;
      test_ctrl     = '0;
      dfe_in[0]     = '0;
      dfe_in[1]     = '0;
      cyc           = 0;
      errors        = 0;
      tests_failed  = 0;
      cap_phase     = 0;
      cap_cnt       = 0;
      cap_n         = 0;
      collect_on    = 1'b0;
      mrkr_req      = 1'b0;
      force_invalid = 1'b0;

      // 1 reset, first edge still shows the state before reset took effect
      e0 = errors;
      for (int i = 0; i < 6; i++) begin
         step_cycle();
         if (i == 2) resetn <= 1'b1;
         if (i > 0 && (dfe_out.valid !== 1'b0 || start_ack !== 1'b0)) begin
            $display("FAIL %0t: valid or start_ack not low around reset", $time);
            errors++;
         end
      end
      report_test("reset", e0);

      // 2 handshake with nothing enabled
      e0 = errors;
      set_ctrl(1'b0, 1'b0, 1'b0, 0, 4);
      step_cycle();
      do_start();
      repeat (16) step_cycle();
      if (dut_state() != SEQ_IDLE) begin
         $display("FAIL %0t: sequencer left idle with no mode", $time);
         errors++;
      end
      report_test("handshake", e0);

      // 3 capture on antenna 0 then single playback
      e0 = errors;
      r  = $urandom;
      n3 = 1 + int'(r % 40);
      run_capture(0, n3, 0, 1'b0);
      run_playback(n3, 1'b0);
      report_test("capture_ant0", e0);

      // 4 capture on antenna 1 with a stray start
      e0 = errors;
      r  = $urandom;
      n4 = 8 + int'(r % 33);
      run_capture(1, n4, 0, 1'b1);
      repeat (16) step_cycle();
      if (dut_state() != SEQ_IDLE) begin
         $display("FAIL %0t: stray start launched a new run", $time);
         errors++;
      end
      run_playback(n4, 1'b0);
      foreach (got_q[k]) begin
         foreach (other_q[j]) begin
            if (got_q[k].data === other_q[j]) begin
               $display("FAIL %0t: beat %0d carries antenna 0 data", $time, k);
               errors++;
            end
         end
      end
      report_test("capture_ant1", e0);

      // 5 loop playback
      e0 = errors;
      run_playback(n4, 1'b1);
      report_test("loop_play", e0);

      // 6 aborted capture over the antenna 1 data
      e0 = errors;
      run_capture(0, n4, 3, 1'b0);
      run_playback(n4, 1'b0);
      report_test("abort_capture", e0);

      $display("tests 6, failed %0d, errors %0d", tests_failed, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- build.f
common/fhbuf_pkg.sv
hdl/start_sync.sv
hdl/sample_ram.sv
fhbuf_ctrl/fhbuf_addr_seq.sv
fhbuf_ctrl/fhbuf_out_drive.sv
hdl/fhbuf_input.sv
verif/tb_fhbuf_input.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_fhbuf_input
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
